// File: verilog/i3c_pkg.sv
// I3C bus-level types shared by the standby target blocks
`default_nettype none

package i3c_pkg;

  // Target FSM states
  typedef enum logic [2:0] {
    BusIdle     = 3'd0,
    BusHeader   = 3'd1,
    BusHdrAck   = 3'd2,
    BusWrByte   = 3'd3,
    BusWrParity = 3'd4,
    BusRdByte   = 3'd5,
    BusRdTbit   = 3'd6,
    BusWaitStop = 3'd7
  } bus_state_e;

  // Transfer kind seen by the flow adapter
  typedef enum logic [1:0] {
    XferNone  = 2'd0,
    XferWrite = 2'd1,
    XferRead  = 2'd2
  } xfer_type_e;

  // Address header as it appears on the bus, rnw last
  typedef struct packed {
    logic [6:0] addr;
    logic       rnw;
  } addr_hdr_t;

  // Broadcast address, write only
  localparam logic [6:0] I3cBroadcastAddr = 7'h7E;

endpackage

`default_nettype wire

// File: verilog/controller_pkg.sv
// Controller-side configuration, event and byte stream types
`default_nettype none

package controller_pkg;

  typedef struct packed {
    logic        enable;
    logic        sta_addr_valid;
    logic [6:0]  sta_addr;
    logic        dyn_addr_valid;
    logic [6:0]  dyn_addr;
    // clk cycles from SCL falling to SDA change
    logic [7:0]  t_hd_dat;
    // clk cycles from SCL rising to release after the T bit
    logic [15:0] t_su_dat;
  } ctrl_cfg_t;

  typedef struct packed {
    logic       valid;
    logic [7:0] data;
  } byte_strm_t;

  // One-cycle event pulses
  typedef struct packed {
    logic nack;
    logic cmd_complete;
    logic parity_err;
    logic read_cmd;
  } ctrl_evt_t;

endpackage

`default_nettype wire

// File: verilog/bus_monitor.sv
// Bus monitor: synchronizes SCL/SDA and flags START, STOP and SCL edges
`timescale 1ns/1ps
`default_nettype none

module bus_monitor (
  input  logic clk_i,
  input  logic rst_n_i,
  input  logic enable_i,
  input  logic scl_i,
  input  logic sda_i,
  output logic start_det_o,
  output logic stop_det_o,
  output logic scl_rise_o,
  output logic scl_fall_o,
  output logic sda_o
);

  logic [1:0] scl_sync_q;
  logic [1:0] sda_sync_q;
  logic       scl_s;
  logic       sda_s;
  logic       scl_p;
  logic       sda_p;

  assign scl_s = scl_sync_q[1];
  assign sda_s = sda_sync_q[1];

  // Idle bus is high on both lines
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      scl_sync_q <= 2'b11;
      sda_sync_q <= 2'b11;
      scl_p      <= 1'b1;
      sda_p      <= 1'b1;
    end else begin
      scl_sync_q <= {scl_sync_q[0], scl_i};
      sda_sync_q <= {sda_sync_q[0], sda_i};
      scl_p      <= scl_s;
      sda_p      <= sda_s;
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      start_det_o <= 1'b0;
      stop_det_o  <= 1'b0;
      scl_rise_o  <= 1'b0;
      scl_fall_o  <= 1'b0;
    end else begin
      scl_rise_o  <= enable_i & scl_s & ~scl_p;
      scl_fall_o  <= enable_i & ~scl_s & scl_p;
      // SDA moving while SCL stays high
      start_det_o <= enable_i & scl_s & scl_p & sda_p & ~sda_s;
      stop_det_o  <= enable_i & scl_s & scl_p & ~sda_p & sda_s;
    end
  end

  // Level aligned with the edge pulses
  assign sda_o = sda_p;

endmodule

`default_nettype wire

// File: verilog/addr_match.sv
// Address matcher: registers the header and compares it with the target addresses
`timescale 1ns/1ps
`default_nettype none

module addr_match
  import i3c_pkg::*;
  import controller_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_n_i,
  input  ctrl_cfg_t cfg_i,
  input  addr_hdr_t hdr_i,
  input  logic      hdr_valid_i,
  output logic      ack_o,
  output addr_hdr_t hdr_o,
  output logic      hdr_match_o
);

  logic sta_hit;
  logic dyn_hit;
  logic bcast_hit;

  assign sta_hit   = cfg_i.sta_addr_valid && (hdr_i.addr == cfg_i.sta_addr);
  assign dyn_hit   = cfg_i.dyn_addr_valid && (hdr_i.addr == cfg_i.dyn_addr);
  assign bcast_hit = (hdr_i.addr == I3cBroadcastAddr) && !hdr_i.rnw;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      ack_o       <= 1'b0;
      hdr_match_o <= 1'b0;
    end else begin
      ack_o       <= hdr_valid_i & (sta_hit | dyn_hit | bcast_hit);
      // Broadcast is not reported as an own-address hit
      hdr_match_o <= hdr_valid_i & (sta_hit | dyn_hit);
    end
  end

  always_ff @(posedge clk_i) begin
    if (hdr_valid_i) begin
      hdr_o <= hdr_i;
    end
  end

endmodule

`default_nettype wire

// File: verilog/i3c_target_fsm.sv
// I3C SDR target FSM: header, ACK/NACK, parity-checked writes and T-bit reads
`timescale 1ns/1ps
`default_nettype none

module i3c_target_fsm
  import i3c_pkg::*;
  import controller_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_n_i,
  input  ctrl_cfg_t  cfg_i,
  input  logic       start_det_i,
  input  logic       stop_det_i,
  input  logic       scl_rise_i,
  input  logic       scl_fall_i,
  input  logic       sda_i,
  input  logic       addr_ack_i,
  input  byte_strm_t tx_byte_i,
  input  logic       tx_last_i,
  input  logic       rx_ovf_i,
  output logic       sda_o,
  output logic       sel_od_pp_o,
  output addr_hdr_t  hdr_o,
  output logic       hdr_valid_o,
  output byte_strm_t rx_byte_o,
  output xfer_type_e xfer_type_o,
  output logic       tx_byte_ready_o,
  output ctrl_evt_t  evt_o
);

  bus_state_e  state_q;
  logic [2:0]  bit_cnt_q;
  logic [7:0]  shift_q;
  logic [7:0]  rx_data_q;
  logic        rx_valid_q;
  logic        ack_q;
  logic        last_q;
  xfer_type_e  xfer_q;
  ctrl_evt_t   evt_q;

  // Pending SDA change, applied after a delay
  logic        drv_pend_q;
  logic        drv_val_q;
  logic        drv_pp_q;
  logic [15:0] dly_lim_q;
  logic [15:0] dly_cnt_q;
  logic        sda_q;
  logic        pp_q;

  logic        bus_cond;
  logic        tx_load;
  logic [7:0]  tx_data;
  logic        sched_val;
  logic        sched_pp;

  assign bus_cond = start_det_i | stop_det_i;

  // First SCL fall of a read byte fetches it
  assign tx_load         = (state_q == BusRdByte) && scl_fall_i && (bit_cnt_q == 3'd0);
  assign tx_byte_ready_o = tx_load;
  assign tx_data         = tx_byte_i.valid ? tx_byte_i.data : 8'hFF;

  // SDA value for the bit that starts at this SCL fall
  always_comb begin
    sched_val = 1'b1;
    sched_pp  = 1'b0;
    case (state_q)
      BusHdrAck: sched_val = ~ack_q;
      BusRdByte: begin
        sched_val = tx_load ? tx_data[7] : shift_q[7];
        sched_pp  = 1'b1;
      end
      BusRdTbit: begin
        sched_val = ~last_q;
        sched_pp  = 1'b1;
      end
      default: ;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q     <= BusIdle;
      bit_cnt_q   <= 3'd0;
      ack_q       <= 1'b0;
      last_q      <= 1'b0;
      xfer_q      <= XferNone;
      evt_q       <= '0;
      hdr_valid_o <= 1'b0;
      rx_valid_q  <= 1'b0;
    end else begin
      evt_q       <= '0;
      hdr_valid_o <= 1'b0;
      rx_valid_q  <= 1'b0;
      if (bus_cond) begin
        evt_q.cmd_complete <= (xfer_q != XferNone);
        xfer_q    <= XferNone;
        state_q   <= start_det_i ? BusHeader : BusIdle;
        bit_cnt_q <= 3'd0;
        ack_q     <= 1'b0;
      end else begin
        if (addr_ack_i) begin
          ack_q <= 1'b1;
        end
        case (state_q)
          BusHeader: begin
            if (scl_rise_i) begin
              bit_cnt_q <= bit_cnt_q + 3'd1;
              if (bit_cnt_q == 3'd7) begin
                hdr_valid_o <= 1'b1;
                state_q     <= BusHdrAck;
              end
            end
          end
          BusHdrAck: begin
            if (scl_rise_i) begin
              if (!ack_q) begin
                evt_q.nack <= 1'b1;
                state_q    <= BusWaitStop;
              end else if (shift_q[0]) begin
                xfer_q         <= XferRead;
                evt_q.read_cmd <= 1'b1;
                state_q        <= BusRdByte;
              end else begin
                xfer_q  <= XferWrite;
                state_q <= BusWrByte;
              end
            end
          end
          BusWrByte: begin
            if (scl_rise_i) begin
              bit_cnt_q <= bit_cnt_q + 3'd1;
              if (bit_cnt_q == 3'd7) begin
                state_q <= BusWrParity;
              end
            end
          end
          BusWrParity: begin
            if (scl_rise_i) begin
              state_q <= BusWrByte;
              // Odd parity over data and T
              if (^{shift_q, sda_i}) begin
                rx_valid_q <= 1'b1;
              end else begin
                evt_q.parity_err <= 1'b1;
              end
            end
          end
          BusRdByte: begin
            if (tx_load) begin
              last_q <= tx_byte_i.valid ? tx_last_i : 1'b1;
            end
            if (scl_rise_i) begin
              bit_cnt_q <= bit_cnt_q + 3'd1;
              if (bit_cnt_q == 3'd7) begin
                state_q <= BusRdTbit;
              end
            end
          end
          BusRdTbit: begin
            if (scl_rise_i) begin
              state_q <= last_q ? BusWaitStop : BusRdByte;
            end
          end
          default: ;
        endcase
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (tx_load) begin
      shift_q <= {tx_data[6:0], 1'b0};
    end else if (scl_fall_i && (state_q == BusRdByte)) begin
      shift_q <= {shift_q[6:0], 1'b0};
    end else if (scl_rise_i && (state_q inside {BusHeader, BusWrByte})) begin
      shift_q <= {shift_q[6:0], sda_i};
    end
    if (scl_rise_i && (state_q == BusWrParity)) begin
      rx_data_q <= shift_q;
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      drv_pend_q <= 1'b0;
      drv_val_q  <= 1'b1;
      drv_pp_q   <= 1'b0;
      dly_lim_q  <= 16'd0;
      dly_cnt_q  <= 16'd0;
      sda_q      <= 1'b1;
      pp_q       <= 1'b0;
    end else if (bus_cond) begin
      drv_pend_q <= 1'b0;
      sda_q      <= 1'b1;
      pp_q       <= 1'b0;
    end else if (scl_fall_i && (state_q != BusIdle)) begin
      drv_pend_q <= 1'b1;
      drv_val_q  <= sched_val;
      drv_pp_q   <= sched_pp;
      dly_lim_q  <= {8'd0, cfg_i.t_hd_dat};
      dly_cnt_q  <= 16'd0;
    end else if (scl_rise_i && (state_q == BusRdTbit)) begin
      // Hand SDA back to the controller after the T bit
      drv_pend_q <= 1'b1;
      drv_val_q  <= 1'b1;
      drv_pp_q   <= 1'b0;
      dly_lim_q  <= cfg_i.t_su_dat;
      dly_cnt_q  <= 16'd0;
    end else if (drv_pend_q) begin
      if (dly_cnt_q == dly_lim_q) begin
        drv_pend_q <= 1'b0;
        sda_q      <= drv_val_q;
        pp_q       <= drv_pp_q;
      end else begin
        dly_cnt_q <= dly_cnt_q + 16'd1;
      end
    end
  end

  assign sda_o       = sda_q;
  assign sel_od_pp_o = pp_q;
  assign hdr_o       = addr_hdr_t'(shift_q);
  assign rx_byte_o   = '{valid: rx_valid_q, data: rx_data_q};
  assign xfer_type_o = xfer_q;

  // RX overflow in the adapter also reports as nack
  always_comb begin
    evt_o      = evt_q;
    evt_o.nack = evt_q.nack | rx_ovf_i;
  end

endmodule

`default_nettype wire

// File: verilog/flow_standby_i3c.sv
// Flow adapter: packs RX bytes into queue words and unpacks TX words into bytes
`timescale 1ns/1ps
`default_nettype none

module flow_standby_i3c
  import i3c_pkg::*;
  import controller_pkg::*;
#(
  parameter int unsigned RxDataWidth = 32,
  parameter int unsigned TxDataWidth = 32
) (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  input  xfer_type_e             xfer_type_i,
  input  logic                   stop_det_i,
  input  byte_strm_t             rx_byte_i,
  output byte_strm_t             tx_byte_o,
  output logic                   tx_last_o,
  input  logic                   tx_byte_ready_i,
  output logic                   rx_ovf_o,
  output logic                   rx_queue_wvalid_o,
  input  logic                   rx_queue_wready_i,
  output logic [RxDataWidth-1:0] rx_queue_wdata_o,
  output logic                   rx_queue_wflush_o,
  input  logic                   tx_queue_empty_i,
  input  logic                   tx_queue_rvalid_i,
  output logic                   tx_queue_rready_o,
  input  logic [TxDataWidth-1:0] tx_queue_rdata_i
);

  localparam int unsigned RxBytes = RxDataWidth / 8;
  localparam int unsigned TxBytes = TxDataWidth / 8;
  localparam int unsigned RxIdxW  = (RxBytes > 1) ? $clog2(RxBytes) : 1;
  localparam int unsigned TxIdxW  = (TxBytes > 1) ? $clog2(TxBytes) : 1;

  logic [RxDataWidth-1:0] rx_word_q;
  logic [RxIdxW-1:0]      rx_idx_q;
  logic                   rx_wvalid_q;
  logic                   rx_wflush_q;

  logic [TxDataWidth-1:0] tx_word_q;
  logic [TxIdxW-1:0]      tx_idx_q;
  logic                   tx_have_q;
  logic                   tx_final;

  // Word is zeroed after each handoff so a flushed word is zero-filled
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rx_word_q   <= '0;
      rx_idx_q    <= '0;
      rx_wvalid_q <= 1'b0;
      rx_wflush_q <= 1'b0;
    end else if (rx_wvalid_q && rx_queue_wready_i) begin
      rx_word_q   <= '0;
      rx_wvalid_q <= 1'b0;
      rx_wflush_q <= 1'b0;
    end else if (rx_byte_i.valid && !rx_wvalid_q) begin
      rx_word_q[8*rx_idx_q +: 8] <= rx_byte_i.data;
      if (rx_idx_q == RxIdxW'(RxBytes - 1)) begin
        rx_idx_q    <= '0;
        rx_wvalid_q <= 1'b1;
      end else begin
        rx_idx_q <= rx_idx_q + 1'b1;
      end
    end else if (stop_det_i && (rx_idx_q != '0) && !rx_wvalid_q) begin
      rx_idx_q    <= '0;
      rx_wvalid_q <= 1'b1;
      rx_wflush_q <= 1'b1;
    end
  end

  // Byte lost while a word waits on the queue
  assign rx_ovf_o          = rx_byte_i.valid & rx_wvalid_q;
  assign rx_queue_wvalid_o = rx_wvalid_q;
  assign rx_queue_wflush_o = rx_wflush_q;
  assign rx_queue_wdata_o  = rx_word_q;

  assign tx_final          = (tx_idx_q == TxIdxW'(TxBytes - 1));
  assign tx_queue_rready_o = !tx_have_q && (xfer_type_i == XferRead);
  assign tx_byte_o         = '{valid: tx_have_q, data: tx_word_q[8*tx_idx_q +: 8]};
  assign tx_last_o         = tx_have_q && tx_final && tx_queue_empty_i;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      tx_have_q <= 1'b0;
      tx_idx_q  <= '0;
    end else if (tx_queue_rvalid_i && tx_queue_rready_o) begin
      tx_have_q <= 1'b1;
      tx_idx_q  <= '0;
    end else if (tx_byte_ready_i && tx_have_q) begin
      if (tx_final) begin
        tx_have_q <= 1'b0;
        tx_idx_q  <= '0;
      end else begin
        tx_idx_q <= tx_idx_q + 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (tx_queue_rvalid_i && tx_queue_rready_o) begin
      tx_word_q <= tx_queue_rdata_i;
    end
  end

endmodule

`default_nettype wire

// File: verilog/controller_standby_i3c.sv
// Standby I3C controller acting as an SDR target with RX/TX data queues
`timescale 1ns/1ps
`default_nettype none

module controller_standby_i3c
  import i3c_pkg::*;
  import controller_pkg::*;
#(
  parameter int unsigned RxDataWidth = 32,
  parameter int unsigned TxDataWidth = 32
) (
  input  logic                   clk_i,
  input  logic                   rst_n_i,

  // Bus pins
  input  logic                   ctrl_scl_i,
  input  logic                   ctrl_sda_i,
  output logic                   ctrl_scl_o,
  output logic                   ctrl_sda_o,
  output logic                   phy_sel_od_pp_o,

  input  ctrl_cfg_t              cfg_i,

  // RX data queue
  output logic                   rx_queue_wvalid_o,
  input  logic                   rx_queue_wready_i,
  output logic [RxDataWidth-1:0] rx_queue_wdata_o,
  output logic                   rx_queue_wflush_o,

  // TX data queue
  input  logic                   tx_queue_empty_i,
  input  logic                   tx_queue_rvalid_i,
  output logic                   tx_queue_rready_o,
  input  logic [TxDataWidth-1:0] tx_queue_rdata_i,

  output ctrl_evt_t              evt_o,
  output logic                   bus_start_o,
  output logic                   bus_stop_o,
  output addr_hdr_t              bus_addr_o,
  output logic                   bus_addr_valid_o
);

  logic       start_det;
  logic       stop_det;
  logic       scl_rise;
  logic       scl_fall;
  logic       sda_s;
  addr_hdr_t  hdr;
  logic       hdr_valid;
  logic       addr_ack;
  byte_strm_t rx_byte;
  xfer_type_e xfer_type;
  byte_strm_t tx_byte;
  logic       tx_last;
  logic       tx_byte_ready;
  logic       rx_ovf;

  // Target never stretches SCL
  assign ctrl_scl_o  = 1'b1;
  assign bus_start_o = start_det;
  assign bus_stop_o  = stop_det;

  bus_monitor u_bus_monitor (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .enable_i    (cfg_i.enable),
    .scl_i       (ctrl_scl_i),
    .sda_i       (ctrl_sda_i),
    .start_det_o (start_det),
    .stop_det_o  (stop_det),
    .scl_rise_o  (scl_rise),
    .scl_fall_o  (scl_fall),
    .sda_o       (sda_s)
  );

  i3c_target_fsm u_i3c_target_fsm (
    .clk_i           (clk_i),
    .rst_n_i         (rst_n_i),
    .cfg_i           (cfg_i),
    .start_det_i     (start_det),
    .stop_det_i      (stop_det),
    .scl_rise_i      (scl_rise),
    .scl_fall_i      (scl_fall),
    .sda_i           (sda_s),
    .addr_ack_i      (addr_ack),
    .tx_byte_i       (tx_byte),
    .tx_last_i       (tx_last),
    .rx_ovf_i        (rx_ovf),
    .sda_o           (ctrl_sda_o),
    .sel_od_pp_o     (phy_sel_od_pp_o),
    .hdr_o           (hdr),
    .hdr_valid_o     (hdr_valid),
    .rx_byte_o       (rx_byte),
    .xfer_type_o     (xfer_type),
    .tx_byte_ready_o (tx_byte_ready),
    .evt_o           (evt_o)
  );

  addr_match u_addr_match (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .cfg_i       (cfg_i),
    .hdr_i       (hdr),
    .hdr_valid_i (hdr_valid),
    .ack_o       (addr_ack),
    .hdr_o       (bus_addr_o),
    .hdr_match_o (bus_addr_valid_o)
  );

  flow_standby_i3c #(
    .RxDataWidth (RxDataWidth),
    .TxDataWidth (TxDataWidth)
  ) u_flow_standby_i3c (
    .clk_i             (clk_i),
    .rst_n_i           (rst_n_i),
    .xfer_type_i       (xfer_type),
    .stop_det_i        (stop_det),
    .rx_byte_i         (rx_byte),
    .tx_byte_o         (tx_byte),
    .tx_last_o         (tx_last),
    .tx_byte_ready_i   (tx_byte_ready),
    .rx_ovf_o          (rx_ovf),
    .rx_queue_wvalid_o (rx_queue_wvalid_o),
    .rx_queue_wready_i (rx_queue_wready_i),
    .rx_queue_wdata_o  (rx_queue_wdata_o),
    .rx_queue_wflush_o (rx_queue_wflush_o),
    .tx_queue_empty_i  (tx_queue_empty_i),
    .tx_queue_rvalid_i (tx_queue_rvalid_i),
    .tx_queue_rready_o (tx_queue_rready_o),
    .tx_queue_rdata_i  (tx_queue_rdata_i)
  );

endmodule

`default_nettype wire

// File: tests/tb_clk_gen.sv
// Testbench clock and reset generator, 20 ns period
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen (
  output logic clk_o,
  output logic rst_n_o
);

  initial begin
    clk_o = 1'b0;
    forever #10 clk_o = ~clk_o;
  end

  // Reset held for four cycles
  initial begin
    rst_n_o = 1'b0;
    repeat (4) @(posedge clk_o);
    #2 rst_n_o = 1'b1;
  end

endmodule

`default_nettype wire

// File: tests/controller_standby_i3c_properties.sv
// Concurrent checks on the standby I3C target top-level ports
`timescale 1ns/1ps
`default_nettype none

module controller_standby_i3c_properties
  import i3c_pkg::*;
(
  input logic        clk_i,
  input logic        rst_n_i,
  input logic        sda_i,
  input logic        pp_i,
  input logic        wvalid_i,
  input logic        wready_i,
  input logic [31:0] wdata_i,
  input logic        stop_i,
  input logic        addr_valid_i,
  input addr_hdr_t   addr_i
);

  // Stalled RX word stays put
  a_rx_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    wvalid_i && !wready_i |=> wvalid_i && $stable(wdata_i))
    else $error("RX word changed under back-pressure");

  // SDA handed back in open drain once STOP is seen
  a_stop_release: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    stop_i |=> sda_i && !pp_i)
    else $error("SDA not released in open drain after STOP");

  // Broadcast header is never an own-address match
  a_bcast_no_match: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    addr_valid_i |-> addr_i.addr != I3cBroadcastAddr)
    else $error("bus_addr_valid_o raised for the broadcast address");

endmodule

bind controller_standby_i3c controller_standby_i3c_properties u_properties (
  .clk_i        (clk_i),
  .rst_n_i      (rst_n_i),
  .sda_i        (ctrl_sda_o),
  .pp_i         (phy_sel_od_pp_o),
  .wvalid_i     (rx_queue_wvalid_o),
  .wready_i     (rx_queue_wready_i),
  .wdata_i      (rx_queue_wdata_o),
  .stop_i       (bus_stop_o),
  .addr_valid_i (bus_addr_valid_o),
  .addr_i       (bus_addr_o)
);

`default_nettype wire

// File: tests/tb_controller_standby_i3c.sv
// Testbench for the standby I3C target with a bit-banged bus controller
`timescale 1ns/1ps
`default_nettype none

module tb_controller_standby_i3c
  import i3c_pkg::*;
  import controller_pkg::*;
;

  typedef struct packed {
    logic [6:0]  addr;
    logic        rnw;
    logic [3:0]  nbytes;
    logic [63:0] data;
    logic [3:0]  bad_idx;
    logic        stall;
    logic        exp_ack;
    logic        exp_match;
  } row_t;

  localparam int NumRows = 7;

  logic        clk;
  logic        rst_n;
  logic        scl_drv;
  logic        sda_drv;
  wire         sda_bus;
  ctrl_cfg_t   cfg;
  logic        rx_ready;
  logic [31:0] tx_mem [4];
  int          tx_rd;
  int          tx_cnt;
  logic        tx_pop;
  logic        ctrl_scl_o;
  logic        ctrl_sda_o;
  logic        phy_sel_od_pp_o;
  logic        rx_queue_wvalid_o;
  logic [31:0] rx_queue_wdata_o;
  logic        rx_queue_wflush_o;
  logic        tx_queue_rready_o;
  ctrl_evt_t   evt_o;
  logic        bus_start_o;
  logic        bus_stop_o;
  addr_hdr_t   bus_addr_o;
  logic        bus_addr_valid_o;

  row_t        rows [NumRows];
  ctrl_evt_t   evt_seen;
  logic        match_seen;
  int          start_cnt;
  int          stop_cnt;
  logic [31:0] rx_words [$];
  logic        rx_flushes [$];
  int          cycle_cnt;
  int          cycle_limit;

  assign sda_bus = sda_drv & ctrl_sda_o;

  tb_clk_gen u_tb_clk_gen (
    .clk_o   (clk),
    .rst_n_o (rst_n)
  );

  controller_standby_i3c u_controller_standby_i3c (
    .clk_i             (clk),
    .rst_n_i           (rst_n),
    .ctrl_scl_i        (scl_drv),
    .ctrl_sda_i        (sda_bus),
    .ctrl_scl_o        (ctrl_scl_o),
    .ctrl_sda_o        (ctrl_sda_o),
    .phy_sel_od_pp_o   (phy_sel_od_pp_o),
    .cfg_i             (cfg),
    .rx_queue_wvalid_o (rx_queue_wvalid_o),
    .rx_queue_wready_i (rx_ready),
    .rx_queue_wdata_o  (rx_queue_wdata_o),
    .rx_queue_wflush_o (rx_queue_wflush_o),
    .tx_queue_empty_i  (tx_rd >= tx_cnt),
    .tx_queue_rvalid_i (tx_rd < tx_cnt),
    .tx_queue_rready_o (tx_queue_rready_o),
    .tx_queue_rdata_i  (tx_mem[tx_rd[1:0]]),
    .evt_o             (evt_o),
    .bus_start_o       (bus_start_o),
    .bus_stop_o        (bus_stop_o),
    .bus_addr_o        (bus_addr_o),
    .bus_addr_valid_o  (bus_addr_valid_o)
  );

  // Bus observers
  always @(posedge clk) begin
    evt_seen = evt_seen | evt_o;
    if (bus_addr_valid_o) match_seen = 1'b1;
    if (bus_start_o) start_cnt++;
    if (bus_stop_o) stop_cnt++;
    if (rst_n && rx_queue_wvalid_o && rx_ready) begin
      rx_words.push_back(rx_queue_wdata_o);
      rx_flushes.push_back(rx_queue_wflush_o);
    end
  end

  // TX queue model popping on a valid/ready edge
  initial begin
    forever begin
      @(posedge clk);
      tx_pop = (tx_rd < tx_cnt) && tx_queue_rready_o;
      #2;
      if (tx_pop) tx_rd++;
    end
  end

  always @(posedge clk) begin
    cycle_cnt++;
    if (cycle_limit > 0 && cycle_cnt > cycle_limit) begin
      stop_on_error("Timeout: run exceeded its cycle limit");
    end
  end

  task automatic stop_on_error(input string msg);
    $display("%s", msg);
    $display("TEST RESULT: FAIL");
    $fatal(1);
  endtask

  task automatic check_hdr(input string name, input addr_hdr_t got, input addr_hdr_t exp);
    if (got !== exp) begin
      stop_on_error($sformatf("MISMATCH at %0t: %s got %h expected %h", $time, name, got, exp));
    end
  endtask

  task automatic check_word(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      stop_on_error($sformatf("MISMATCH at %0t: %s got %h expected %h", $time, name, got, exp));
    end
  endtask

  task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
    if (got !== exp) begin
      stop_on_error($sformatf("MISMATCH at %0t: %s got %h expected %h", $time, name, got, exp));
    end
  endtask

  task automatic check_evt(input string name, input ctrl_evt_t got, input ctrl_evt_t exp);
    if (got !== exp) begin
      stop_on_error($sformatf("MISMATCH at %0t: %s got %b expected %b", $time, name, got, exp));
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      stop_on_error($sformatf("MISMATCH at %0t: %s got %b expected %b", $time, name, got, exp));
    end
  endtask

  task automatic check_count(input string name, input int got, input int exp);
    if (got != exp) begin
      stop_on_error($sformatf("MISMATCH at %0t: %s got %0d expected %0d", $time, name, got, exp));
    end
  endtask

  task automatic wait_clk(input int n);
    repeat (n) @(posedge clk);
    #2;
  endtask

  task automatic send_start();
    wait_clk(4);
    sda_drv = 1'b0;
    wait_clk(8);
    scl_drv = 1'b0;
    wait_clk(1);
  endtask

  // One SCL pulse with SCL low on entry and exit
  task automatic clock_bit(input logic b, output logic s, output logic pp);
    sda_drv = b;
    wait_clk(7);
    scl_drv = 1'b1;
    wait_clk(4);
    s  = sda_bus;
    pp = phy_sel_od_pp_o;
    wait_clk(4);
    scl_drv = 1'b0;
    wait_clk(1);
  endtask

  task automatic send_stop();
    sda_drv = 1'b0;
    wait_clk(7);
    scl_drv = 1'b1;
    wait_clk(8);
    sda_drv = 1'b1;
    wait_clk(8);
  endtask

  function automatic row_t make_row(input logic [6:0] addr, input logic rnw,
                                    input logic [3:0] n, input logic [63:0] data,
                                    input logic [3:0] bad, input logic stall,
                                    input logic ack, input logic match);
    row_t r;
    r = '{addr, rnw, n, data, bad, stall, ack, match};
    return r;
  endfunction

  initial begin
    row_t        r;
    addr_hdr_t   hdr;
    ctrl_evt_t   exp_evt;
    logic [7:0]  b;
    logic [7:0]  got;
    logic        s;
    logic        pp;
    logic [31:0] cur;
    logic [31:0] exp_words [$];
    logic        exp_flush [$];
    int          pos;
    int          s0;
    int          p0;

    scl_drv     = 1'b1;
    sda_drv     = 1'b1;
    rx_ready    = 1'b1;
    tx_rd       = 0;
    tx_cnt      = 0;
    tx_pop      = 1'b0;
    evt_seen    = '0;
    match_seen  = 1'b0;
    start_cnt   = 0;
    stop_cnt    = 0;
    cycle_cnt   = 0;
    cycle_limit = 0;
    foreach (tx_mem[i]) tx_mem[i] = 32'h0;
    cfg = '{enable: 1'b1, sta_addr_valid: 1'b1, sta_addr: 7'h51,
            dyn_addr_valid: 1'b1, dyn_addr: 7'h2A, t_hd_dat: 8'd2, t_su_dat: 16'd40};

    // addr, rnw, bytes, data (byte 0 in the low end), bad byte, stall, ack, match
    rows[0] = make_row(7'h2A, 1'b0, 4'd6, 64'h0000_A6A5_A4A3_A2A1, 4'hF, 1'b0, 1'b1, 1'b1);
    rows[1] = make_row(7'h51, 1'b0, 4'd1, 64'h0000_0000_0000_005C, 4'hF, 1'b0, 1'b1, 1'b1);
    rows[2] = make_row(7'h33, 1'b0, 4'd0, 64'h0, 4'hF, 1'b0, 1'b0, 1'b0);
    rows[3] = make_row(7'h7E, 1'b0, 4'd0, 64'h0, 4'hF, 1'b0, 1'b1, 1'b0);
    rows[4] = make_row(7'h2A, 1'b0, 4'd5, 64'h0000_00E5_E4E3_E2E1, 4'd2, 1'b1, 1'b1, 1'b1);
    rows[5] = make_row(7'h51, 1'b1, 4'd8, 64'hC8C7_C6C5_C4C3_C2C1, 4'hF, 1'b0, 1'b1, 1'b1);
    rows[6] = make_row(7'h7E, 1'b1, 4'd0, 64'h0, 4'hF, 1'b0, 1'b0, 1'b0);

    cycle_limit = 500;
    for (int i = 0; i < NumRows; i++) begin
      cycle_limit += (int'(rows[i].nbytes) + 2) * 9 * 16;
    end

    @(posedge rst_n);
    wait_clk(4);

    // Idle outputs after reset
    check_bit("ctrl_scl_o", ctrl_scl_o, 1'b1);
    check_bit("ctrl_sda_o", ctrl_sda_o, 1'b1);
    check_bit("phy_sel_od_pp_o", phy_sel_od_pp_o, 1'b0);
    check_bit("rx_queue_wvalid_o", rx_queue_wvalid_o, 1'b0);
    check_bit("tx_queue_rready_o", tx_queue_rready_o, 1'b0);
    check_bit("bus_start_o", bus_start_o, 1'b0);
    check_bit("bus_stop_o", bus_stop_o, 1'b0);
    check_bit("bus_addr_valid_o", bus_addr_valid_o, 1'b0);
    check_evt("evt_o", evt_o, '0);

    for (int ri = 0; ri < NumRows; ri++) begin
      r          = rows[ri];
      hdr        = '{addr: r.addr, rnw: r.rnw};
      evt_seen   = '0;
      match_seen = 1'b0;
      s0         = start_cnt;
      p0         = stop_cnt;
      rx_ready   = !r.stall;
      if (r.rnw) begin
        tx_mem[0] = r.data[31:0];
        tx_mem[1] = r.data[63:32];
        tx_rd     = 0;
        tx_cnt    = int'(r.nbytes) / 4;
      end

      send_start();
      for (int k = 7; k >= 0; k--) begin
        clock_bit(hdr[k], s, pp);
      end
      clock_bit(1'b1, s, pp);
      check_bit("SDA on ACK bit", s, !r.exp_ack);
      check_bit("bus_addr_valid_o pulse", match_seen, r.exp_match);
      check_hdr("bus_addr_o", bus_addr_o, hdr);

      if (r.exp_ack) begin
        for (int i = 0; i < int'(r.nbytes); i++) begin
          b = r.data[8*i +: 8];
          if (!r.rnw) begin
            for (int k = 7; k >= 0; k--) begin
              clock_bit(b[k], s, pp);
            end
            // Odd parity T bit inverted for a corrupted byte
            clock_bit((i == int'(r.bad_idx)) ? ^b : ~^b, s, pp);
          end else begin
            for (int k = 7; k >= 0; k--) begin
              clock_bit(1'b1, s, pp);
              got[k] = s;
              check_bit("phy_sel_od_pp_o", pp, 1'b1);
            end
            check_byte("read byte", got, b);
            clock_bit(1'b1, s, pp);
            check_bit("read T bit", s, i != int'(r.nbytes) - 1);
          end
        end
      end
      send_stop();
      wait_clk(4);

      check_count("bus_start_o pulses", start_cnt - s0, 1);
      check_count("bus_stop_o pulses", stop_cnt - p0, 1);
      exp_evt.nack         = !r.exp_ack;
      exp_evt.cmd_complete = r.exp_ack;
      exp_evt.parity_err   = r.exp_ack && !r.rnw && (r.bad_idx < r.nbytes);
      exp_evt.read_cmd     = r.exp_ack && r.rnw;
      check_evt("evt_o", evt_seen, exp_evt);

      // Expected RX words with the first byte in the low end
      exp_words.delete();
      exp_flush.delete();
      if (r.exp_ack && !r.rnw) begin
        cur = '0;
        pos = 0;
        for (int i = 0; i < int'(r.nbytes); i++) begin
          if (i != int'(r.bad_idx)) begin
            cur[8*pos +: 8] = r.data[8*i +: 8];
            pos++;
            if (pos == 4) begin
              exp_words.push_back(cur);
              exp_flush.push_back(1'b0);
              cur = '0;
              pos = 0;
            end
          end
        end
        if (pos != 0) begin
          exp_words.push_back(cur);
          exp_flush.push_back(1'b1);
        end
      end

      if (r.stall) begin
        check_bit("rx_queue_wvalid_o", rx_queue_wvalid_o, 1'b1);
        check_word("rx_queue_wdata_o", rx_queue_wdata_o, exp_words[0]);
        rx_ready = 1'b1;
        wait_clk(3);
      end

      check_count("RX word count", rx_words.size(), exp_words.size());
      foreach (exp_words[i]) begin
        check_word("rx_queue_wdata_o", rx_words[i], exp_words[i]);
        check_bit("rx_queue_wflush_o", rx_flushes[i], exp_flush[i]);
      end
      rx_words.delete();
      rx_flushes.delete();
      tx_cnt = 0;
      tx_rd  = 0;
      wait_clk(4);
    end

    $display("TEST RESULT: PASS");
    $finish;
  end

endmodule

`default_nettype wire

// File: controller_standby_i3c.f
verilog/i3c_pkg.sv
verilog/controller_pkg.sv
verilog/bus_monitor.sv
verilog/addr_match.sv
verilog/i3c_target_fsm.sv
verilog/flow_standby_i3c.sv
verilog/controller_standby_i3c.sv
tests/tb_clk_gen.sv
tests/controller_standby_i3c_properties.sv
tests/tb_controller_standby_i3c.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Compile and run the standby I3C target testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_controller_standby_i3c \
  -f controller_standby_i3c.f \
  --Mdir obj_dir -o sim > build.log 2>&1 \
  || { cat build.log; echo "Build failed"; exit 1; }

./obj_dir/sim > sim.log 2>&1
cat sim.log

grep -q "TEST RESULT: FAIL" sim.log && exit 1
grep -q "TEST RESULT: PASS" sim.log && exit 0 || exit 1
